// ==== compile.f ====
source/mci_pkg.sv
source/axi_sub.sv
source/mci_axi_sub_decode.sv
source/mci_reg_file.sv
source/mcu_sram.sv
source/mci_axi_sub_top.sv
source/mci_top.sv
dv/mci_top_tb.sv

// ==== dv/mci_top_tb.sv ====
/*
 * Testbench for the MCI subsystem top
 * Drives single-beat AXI traffic, predicts each response from shadow
 * copies of the registers and the SRAM, and checks the B and R channels
 */

`default_nettype none

module mci_top_tb;

    localparam int          sram_kb        = 4;
    localparam int          num_txn        = 304;
    localparam int          cycles_per_txn = 200;
    localparam logic [31:0] reg_bytes      = 32'(mci_pkg::reg_count * 4);
    localparam logic [31:0] sram_bytes     = 32'(sram_kb * 1024);

    // Expected data and response for one address
    typedef struct packed {
        logic [31:0]        data;
        mci_pkg::axi_resp_e resp;
    } ref_t;

    logic             clk;
    logic             rst_n;
    logic             aw_valid;
    logic             aw_ready;
    mci_pkg::axi_aw_t aw;
    logic             w_valid;
    logic             w_ready;
    mci_pkg::axi_w_t  w;
    logic             b_valid;
    logic             b_ready;
    mci_pkg::axi_b_t  b;
    logic             ar_valid;
    logic             ar_ready;
    mci_pkg::axi_ar_t ar;
    logic             r_valid;
    logic             r_ready;
    mci_pkg::axi_r_t  r;

    // Shadow model and expected responses in issue order
    logic [31:0]      reg_shadow [16];
    logic [31:0]      sram_shadow [sram_kb*256];
    logic [9:0]       sram_used [$];
    mci_pkg::axi_b_t  exp_b [$];
    mci_pkg::axi_r_t  exp_r [$];
    logic [1:0]       stall_pat [256];
    logic             stall_en;
    logic             b_stall = 1'b0;
    logic             r_stall = 1'b0;
    mci_pkg::axi_b_t  b_hold;
    mci_pkg::axi_r_t  r_hold;
    logic [3:0]       next_id = 4'd0;
    integer           seed = 76;

    mci_top #(
        .MCU_SRAM_SIZE_KB (sram_kb)
    ) mci_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reports a mismatch and stops at once
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] sram_addr(input logic [9:0] idx);
        return mci_pkg::sram_base + {20'd0, idx, 2'b00};
    endfunction

    // Expected response from the address map and the shadow copies
    function automatic ref_t predict_access(input logic [31:0] addr);
        ref_t        res;
        logic [31:0] off;
        res.data = '0;
        res.resp = mci_pkg::resp_slverr;
        off      = addr - mci_pkg::sram_base;
        if (addr < reg_bytes) begin
            res.data = reg_shadow[addr[5:2]];
            res.resp = mci_pkg::resp_okay;
        end else if (off < sram_bytes) begin
            // Ten bits of word offset for 4 KB
            res.data = sram_shadow[off[11:2]];
            res.resp = mci_pkg::resp_okay;
        end
        return res;
    endfunction

    // Byte-strobe update of the shadow copies
    // Register 0 never takes a write
    function automatic void apply_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        logic [31:0] off;
        off = addr - mci_pkg::sram_base;
        for (int j = 0; j < 4; j++) begin
            if (strb[j] && addr < reg_bytes && addr[5:2] != 4'd0) begin
                reg_shadow[addr[5:2]][j*8 +: 8] = data[j*8 +: 8];
            end else if (strb[j] && off < sram_bytes) begin
                sram_shadow[off[11:2]][j*8 +: 8] = data[j*8 +: 8];
            end
        end
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [3:0] id);
        mci_pkg::axi_b_t want;
        ref_t            res;
        res       = predict_access(addr);
        want.id   = id;
        want.resp = res.resp;
        exp_b.push_back(want);
        apply_write(addr, data, strb);
        @(posedge clk);
        aw_valid <= 1'b1;
        w_valid  <= 1'b1;
        aw       <= '{addr: addr, id: id, user: 4'h0};
        w        <= '{data: data, strb: strb};
        // Ready seen at the falling edge holds through the next rising edge
        @(negedge clk);
        while (!aw_ready) begin
            check_value("w_ready", 64'(w_ready), 64'd0);
            @(negedge clk);
        end
        // Address and data are taken on the same edge
        check_value("w_ready", 64'(w_ready), 64'd1);
        @(posedge clk);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [3:0] id);
        mci_pkg::axi_r_t want;
        ref_t            res;
        res       = predict_access(addr);
        want.id   = id;
        want.data = res.data;
        want.resp = res.resp;
        exp_r.push_back(want);
        @(posedge clk);
        ar_valid <= 1'b1;
        ar       <= '{addr: addr, id: id, user: 4'h0};
        @(negedge clk);
        while (!ar_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        ar_valid <= 1'b0;
    endtask

    // All registers, then every SRAM word written so far
    task automatic read_back_all();
        for (int i = 0; i < mci_pkg::reg_count; i++) begin
            axi_read(32'(i * 4), next_id);
            next_id++;
        end
        foreach (sram_used[k]) begin
            axi_read(sram_addr(sram_used[k]), next_id);
            next_id++;
        end
    endtask

    // Responses are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            // A stalled response keeps valid and payload
            if (b_stall) begin
                check_value("b_valid", 64'(b_valid), 64'd1);
                check_value("b", 64'(b), 64'(b_hold));
            end
            if (r_stall) begin
                check_value("r_valid", 64'(r_valid), 64'd1);
                check_value("r", 64'(r), 64'(r_hold));
            end
            if (b_valid && b_ready) begin
                if (exp_b.size() == 0) begin
                    $display("Write response at %0t with no write outstanding", $time);
                    $display("TESTS FAILED");
                    $fatal(1, "unexpected write response");
                end else begin
                    check_value("b", 64'(b), 64'(exp_b.pop_front()));
                end
            end
            if (r_valid && r_ready) begin
                if (exp_r.size() == 0) begin
                    $display("Read response at %0t with no read outstanding", $time);
                    $display("TESTS FAILED");
                    $fatal(1, "unexpected read response");
                end else begin
                    check_value("r", 64'(r), 64'(exp_r.pop_front()));
                end
            end
            b_stall = b_valid && !b_ready;
            r_stall = r_valid && !r_ready;
            b_hold  = b;
            r_hold  = r;
        end
    end

    // Back-pressure in four-cycle stretches from a random pattern
    initial begin
        logic [9:0] cyc;
        cyc = '0;
        b_ready <= 1'b1;
        r_ready <= 1'b1;
        forever begin
            @(posedge clk);
            b_ready <= ~(stall_en & stall_pat[cyc[9:2]][0]);
            r_ready <= ~(stall_en & stall_pat[cyc[9:2]][1]);
            cyc++;
        end
    end

    initial begin
        repeat (cycles_per_txn * num_txn) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 cycles_per_txn * num_txn);
        $display("TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] wdata;
        logic [3:0]  wr_id;
        logic [3:0]  rd_id;
        logic [31:0] bad_addr [8];
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        ar_valid <= 1'b0;
        aw       <= '0;
        w        <= '0;
        ar       <= '0;
        rst_n    <= 1'b0;
        stall_en <= 1'b0;
        reg_shadow    = '{default: '0};
        reg_shadow[0] = mci_pkg::hw_id;
        // Past word 15 inside the register window, then outside both windows
        bad_addr = '{32'h40, 32'h7C, 32'h800, 32'hFFC,
                     32'h000F_FFFC, 32'h0010_1000, 32'h0020_0000, 32'hFFFF_FFFC};
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_value("b_valid", 64'(b_valid), 64'd0);
        check_value("r_valid", 64'(r_valid), 64'd0);
        read_back_all();

        // Register writes starting with the ID register
        axi_write(32'h0, 32'hFFFF_FFFF, 4'hF, next_id);
        next_id++;
        for (int i = 0; i < 23; i++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            axi_write({26'd0, rnd[3:0], 2'b00}, wdata, rnd[7:4], next_id);
            next_id++;
        end
        read_back_all();

        // SRAM full words, then partial rewrites of the same words
        for (int i = 0; i < 32; i++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            sram_used.push_back(rnd[9:0]);
            axi_write(sram_addr(rnd[9:0]), wdata, 4'hF, next_id);
            next_id++;
        end
        for (int i = 0; i < 16; i++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            axi_write(sram_addr(sram_used[rnd[4:0]]), wdata, rnd[11:8], next_id);
            next_id++;
        end
        read_back_all();

        // Unmapped accesses, then confirm nothing moved
        foreach (bad_addr[k]) begin
            rnd = $random(seed);
            axi_write(bad_addr[k], rnd, 4'hF, next_id);
            next_id++;
            axi_read(bad_addr[k], next_id);
            next_id++;
        end
        read_back_all();

        // Concurrent traffic to disjoint targets under back-pressure
        for (int i = 0; i < 256; i++) begin
            rnd          = $random(seed);
            stall_pat[i] = rnd[1:0];
        end
        stall_en <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            rnd     = $random(seed);
            wdata   = $random(seed);
            wr_id   = next_id;
            rd_id   = next_id + 4'd1;
            next_id = next_id + 4'd2;
            fork
                axi_write({26'd0, rnd[3:0], 2'b00}, wdata, rnd[7:4], wr_id);
                axi_read(sram_addr(sram_used[rnd[12:8]]), rd_id);
            join
        end

        // Every write of the concurrent phase must have landed
        read_back_all();

        // Let the last responses drain
        repeat (200) begin
            if (exp_b.size() != 0 || exp_r.size() != 0) begin
                @(posedge clk);
            end
        end
        if (exp_b.size() == 0 && exp_r.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Run ended with %0d write and %0d read responses missing",
                     exp_b.size(), exp_r.size());
            $display("TESTS FAILED");
            $fatal(1, "missing responses");
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the MCI testbench with Verilator, run it and check the log
rm -f sim.log &&
verilator --binary --timing --assert --top-module mci_top_tb -Mdir obj_dir -f compile.f &&
./obj_dir/Vmci_top_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== source/axi_sub.sv ====
/*
 * AXI subordinate, single beat
 * Arbitrates round-robin between reads and writes, issues one simplex
 * request at a time and returns the matching B or R response
 */

`default_nettype none

module axi_sub #(
    parameter int DATA_WIDTH = mci_pkg::data_width
) (
    input  logic                    clk,
    input  logic                    rst_n,

    // AXI write side
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  mci_pkg::axi_aw_t        aw,
    input  logic                    w_valid,
    output logic                    w_ready,
    input  mci_pkg::axi_w_t         w,
    output logic                    b_valid,
    input  logic                    b_ready,
    output mci_pkg::axi_b_t         b,

    // AXI read side
    input  logic                    ar_valid,
    output logic                    ar_ready,
    input  mci_pkg::axi_ar_t        ar,
    output logic                    r_valid,
    input  logic                    r_ready,
    output mci_pkg::axi_r_t         r,

    // Component side
    output logic                    dv,
    output mci_pkg::cif_req_t       req,
    input  logic                    hold,
    input  logic [DATA_WIDTH-1:0]   rdata,
    input  logic                    error
);

    // Which direction was granted last
    typedef enum logic {
        last_rd,
        last_wr
    } arb_state_e;

    arb_state_e arb_q;
    logic       init_q;
    logic       idle;
    logic       wr_pend;
    logic       rd_block;
    logic       wr_win;
    logic       wr_acc;
    logic       rd_acc;
    logic       done;

    // Free to accept once out of reset with nothing in flight
    assign idle     = init_q & ~dv & ~b_valid & ~r_valid;

    // Write needs address and data together
    assign wr_pend  = aw_valid & w_valid;

    // Read goes first when the last grant was a write
    assign rd_block = ar_valid & (arb_q == last_wr);
    assign wr_win   = wr_pend & ~rd_block;

    // AW and W rise together, AR only when no write wins
    assign aw_ready = idle & w_valid & ~rd_block;
    assign w_ready  = idle & aw_valid & ~rd_block;
    assign ar_ready = idle & ~wr_win;

    assign wr_acc   = aw_valid & aw_ready;
    assign rd_acc   = ar_valid & ar_ready;

    // Request ends on the first cycle without hold
    assign done     = dv & ~hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_q  <= 1'b0;
            arb_q   <= last_rd;
            dv      <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            init_q <= 1'b1;
            if (wr_acc) begin
                arb_q <= last_wr;
            end else if (rd_acc) begin
                arb_q <= last_rd;
            end
            // Strobe stays up while the target holds
            if (wr_acc || rd_acc) begin
                dv <= 1'b1;
            end else if (done) begin
                dv <= 1'b0;
            end
            if (done && req.write) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (done && !req.write) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Request and response payloads
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            req.addr  <= aw.addr;
            req.write <= 1'b1;
            req.wdata <= w.data;
            req.wstrb <= w.strb;
            req.id    <= aw.id;
            req.user  <= aw.user;
        end else if (rd_acc) begin
            req.addr  <= ar.addr;
            req.write <= 1'b0;
            req.wdata <= '0;
            req.wstrb <= '0;
            req.id    <= ar.id;
            req.user  <= ar.user;
        end
        // Both are safe to load, only one valid follows
        if (done) begin
            b.id   <= req.id;
            b.resp <= error ? mci_pkg::resp_slverr : mci_pkg::resp_okay;
            r.id   <= req.id;
            r.data <= rdata;
            r.resp <= error ? mci_pkg::resp_slverr : mci_pkg::resp_okay;
        end
    end

    // One outstanding request at most
    a_dv_no_resp: assert property (@(posedge clk) disable iff (!rst_n)
        dv |-> !(b_valid || r_valid));

    // Stalled responses hold their payload
    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid && $stable(b));
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

`default_nettype wire

// ==== source/mci_axi_sub_decode.sv ====
/*
 * MCI address decoder
 * Steers component requests to the register block or the MCU SRAM
 * and answers unmapped addresses with an error
 */

`default_nettype none

module mci_axi_sub_decode #(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // From the AXI subordinate
    input  logic                              dv,
    input  mci_pkg::cif_req_t                 req,
    output logic                              hold,
    output logic [mci_pkg::data_width-1:0]    rdata,
    output logic                              error,

    // Register block
    output logic                              reg_dv,
    output mci_pkg::cif_req_t                 reg_req,
    input  logic [mci_pkg::data_width-1:0]    reg_rdata,
    input  logic                              reg_hold,

    // MCU SRAM
    output logic                              sram_dv,
    output mci_pkg::cif_req_t                 sram_req,
    input  logic [mci_pkg::data_width-1:0]    sram_rdata,
    input  logic                              sram_hold
);

    localparam int AW = mci_pkg::addr_width;

    // Window sizes in bytes
    localparam logic [AW-1:0] reg_span  = AW'(mci_pkg::reg_count * (mci_pkg::data_width / 8));
    localparam logic [AW-1:0] sram_span = AW'(MCU_SRAM_SIZE_KB * 1024);

    logic [AW-1:0] reg_off;
    logic [AW-1:0] sram_off;
    logic          reg_hit;
    logic          sram_hit;

    // Offsets wrap below the base, so one compare covers the range
    assign reg_off  = req.addr - mci_pkg::reg_base;
    assign sram_off = req.addr - mci_pkg::sram_base;
    assign reg_hit  = reg_off < reg_span;
    assign sram_hit = sram_off < sram_span;

    // Same request to both targets, strobe only to the match
    assign reg_req  = req;
    assign sram_req = req;
    assign reg_dv   = dv & reg_hit;
    assign sram_dv  = dv & sram_hit;

    // No match completes at once
    assign error    = ~reg_hit & ~sram_hit;

    always_comb begin
        hold  = 1'b0;
        rdata = '0;
        if (reg_hit) begin
            hold  = reg_hold;
            rdata = reg_rdata;
        end else if (sram_hit) begin
            hold  = sram_hold;
            rdata = sram_rdata;
        end
    end

    // Address map keeps the targets apart
    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_dv && sram_dv));

endmodule

`default_nettype wire

// ==== source/mci_axi_sub_top.sv ====
/*
 * MCI AXI bridge
 * Collapses AXI to simplex requests and decodes them to the targets
 */

`default_nettype none

module mci_axi_sub_top #(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // AXI
    input  logic                           aw_valid,
    output logic                           aw_ready,
    input  mci_pkg::axi_aw_t               aw,
    input  logic                           w_valid,
    output logic                           w_ready,
    input  mci_pkg::axi_w_t                w,
    output logic                           b_valid,
    input  logic                           b_ready,
    output mci_pkg::axi_b_t                b,
    input  logic                           ar_valid,
    output logic                           ar_ready,
    input  mci_pkg::axi_ar_t               ar,
    output logic                           r_valid,
    input  logic                           r_ready,
    output mci_pkg::axi_r_t                r,

    // Register block request
    output logic                           reg_dv,
    output mci_pkg::cif_req_t              reg_req,
    input  logic [mci_pkg::data_width-1:0] reg_rdata,
    input  logic                           reg_hold,

    // MCU SRAM request
    output logic                           sram_dv,
    output mci_pkg::cif_req_t              sram_req,
    input  logic [mci_pkg::data_width-1:0] sram_rdata,
    input  logic                           sram_hold
);

    // Simplex link between subordinate and decoder
    logic                           dv;
    mci_pkg::cif_req_t              req;
    logic                           hold;
    logic [mci_pkg::data_width-1:0] rdata;
    logic                           error;

    axi_sub #(
        .DATA_WIDTH (mci_pkg::data_width)
    ) i_axi_sub (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .dv       (dv),
        .req      (req),
        .hold     (hold),
        .rdata    (rdata),
        .error    (error)
    );

    mci_axi_sub_decode #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) i_mci_axi_sub_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .dv         (dv),
        .req        (req),
        .hold       (hold),
        .rdata      (rdata),
        .error      (error),
        .reg_dv     (reg_dv),
        .reg_req    (reg_req),
        .reg_rdata  (reg_rdata),
        .reg_hold   (reg_hold),
        .sram_dv    (sram_dv),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata),
        .sram_hold  (sram_hold)
    );

endmodule

`default_nettype wire

// ==== source/mci_pkg.sv ====
/*
 * MCI shared definitions
 * Bus widths, address map, AXI channel payloads and the simplex
 * component request used between the AXI subordinate and its targets
 */

`default_nettype none

package mci_pkg;

    // Bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int id_width   = 4;
    localparam int user_width = 4;

    // Register window, only the first reg_count words decode
    localparam logic [addr_width-1:0] reg_base  = 32'h0000_0000;
    localparam int                    reg_count = 16;

    // SRAM window, size set by the top level parameter
    localparam logic [addr_width-1:0] sram_base = 32'h0010_0000;

    // Value returned by register 0
    localparam logic [data_width-1:0] hw_id = 32'h4D43_4900;

    // AXI response codes in use
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // Write and read address channels
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [id_width-1:0]   id;
        logic [user_width-1:0] user;
    } axi_aw_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [id_width-1:0]   id;
        logic [user_width-1:0] user;
    } axi_ar_t;

    // Write data channel, single beat so no last
    typedef struct packed {
        logic [data_width-1:0]   data;
        logic [data_width/8-1:0] strb;
    } axi_w_t;

    // Write response channel
    typedef struct packed {
        logic [id_width-1:0] id;
        axi_resp_e           resp;
    } axi_b_t;

    // Read data channel
    typedef struct packed {
        logic [id_width-1:0]   id;
        logic [data_width-1:0] data;
        axi_resp_e             resp;
    } axi_r_t;

    // Simplex component request
    typedef struct packed {
        logic [addr_width-1:0]   addr;
        logic                    write;
        logic [data_width-1:0]   wdata;
        logic [data_width/8-1:0] wstrb;
        logic [id_width-1:0]     id;
        logic [user_width-1:0]   user;
    } cif_req_t;

endpackage

`default_nettype wire

// ==== source/mci_reg_file.sv ====
/*
 * MCI register block
 * Register 0 reads the hardware ID, registers 1 to 15 are read/write
 * with byte strobes, reads return combinationally
 */

`default_nettype none

module mci_reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           dv,
    input  mci_pkg::cif_req_t              req,
    output logic [mci_pkg::data_width-1:0] rdata,
    output logic                           hold
);

    localparam int IDX_W  = $clog2(mci_pkg::reg_count);
    localparam int NBYTES = mci_pkg::data_width / 8;

    logic [mci_pkg::data_width-1:0] regs [mci_pkg::reg_count];
    logic [IDX_W-1:0]               idx;

    // Word index within the window
    assign idx = req.addr[2 +: IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Register 0 holds the ID, the rest clear
            for (int i = 0; i < mci_pkg::reg_count; i++) begin
                regs[i] <= (i == 0) ? mci_pkg::hw_id : '0;
            end
        end else if (dv && req.write && idx != '0) begin
            for (int j = 0; j < NBYTES; j++) begin
                if (req.wstrb[j]) begin
                    regs[idx][j*8 +: 8] <= req.wdata[j*8 +: 8];
                end
            end
        end
    end

    assign rdata = regs[idx];

    // Always answers in the same cycle
    assign hold  = 1'b0;

endmodule

`default_nettype wire

// ==== source/mci_top.sv ====
/*
 * MCI subsystem top
 * AXI bridge in front of the register block and the MCU SRAM
 */

`default_nettype none

module mci_top #(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  logic             clk,
    input  logic             rst_n,

    // AXI
    input  logic             aw_valid,
    output logic             aw_ready,
    input  mci_pkg::axi_aw_t aw,
    input  logic             w_valid,
    output logic             w_ready,
    input  mci_pkg::axi_w_t  w,
    output logic             b_valid,
    input  logic             b_ready,
    output mci_pkg::axi_b_t  b,
    input  logic             ar_valid,
    output logic             ar_ready,
    input  mci_pkg::axi_ar_t ar,
    output logic             r_valid,
    input  logic             r_ready,
    output mci_pkg::axi_r_t  r
);

    // Target request ports
    logic                           reg_dv;
    mci_pkg::cif_req_t              reg_req;
    logic [mci_pkg::data_width-1:0] reg_rdata;
    logic                           reg_hold;
    logic                           sram_dv;
    mci_pkg::cif_req_t              sram_req;
    logic [mci_pkg::data_width-1:0] sram_rdata;
    logic                           sram_hold;

    mci_axi_sub_top #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) i_mci_axi_sub_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw         (aw),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w          (w),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .b          (b),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r          (r),
        .reg_dv     (reg_dv),
        .reg_req    (reg_req),
        .reg_rdata  (reg_rdata),
        .reg_hold   (reg_hold),
        .sram_dv    (sram_dv),
        .sram_req   (sram_req),
        .sram_rdata (sram_rdata),
        .sram_hold  (sram_hold)
    );

    mci_reg_file i_mci_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .dv    (reg_dv),
        .req   (reg_req),
        .rdata (reg_rdata),
        .hold  (reg_hold)
    );

    mcu_sram #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) i_mcu_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .dv    (sram_dv),
        .req   (sram_req),
        .rdata (sram_rdata),
        .hold  (sram_hold)
    );

endmodule

`default_nettype wire

// ==== source/mcu_sram.sv ====
/*
 * MCU SRAM model
 * Word array with byte-strobe writes, reads hold one cycle and then
 * return registered data
 */

`default_nettype none

module mcu_sram #(
    parameter int MCU_SRAM_SIZE_KB = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           dv,
    input  mci_pkg::cif_req_t              req,
    output logic [mci_pkg::data_width-1:0] rdata,
    output logic                           hold
);

    localparam int DEPTH  = MCU_SRAM_SIZE_KB * 1024 / (mci_pkg::data_width / 8);
    localparam int IDX_W  = $clog2(DEPTH);
    localparam int NBYTES = mci_pkg::data_width / 8;

    logic [mci_pkg::data_width-1:0] mem [DEPTH];
    logic [mci_pkg::data_width-1:0] rd_q;
    logic [mci_pkg::addr_width-1:0] offset;
    logic [IDX_W-1:0]               word_idx;
    logic                           rd_wait;

    assign offset   = req.addr - mci_pkg::sram_base;
    assign word_idx = offset[2 +: IDX_W];

    // First read cycle stalls while the array is read
    assign hold  = dv & ~req.write & ~rd_wait;
    assign rdata = rd_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= hold;
        end
    end

    always_ff @(posedge clk) begin
        if (dv && req.write) begin
            for (int j = 0; j < NBYTES; j++) begin
                if (req.wstrb[j]) begin
                    mem[word_idx][j*8 +: 8] <= req.wdata[j*8 +: 8];
                end
            end
        end
        if (hold) begin
            rd_q <= mem[word_idx];
        end
    end

    // Decoder only selects addresses inside the array
    a_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        dv |-> (offset >> 2) < DEPTH);

endmodule

`default_nettype wire
